// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_aes
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
RUN_ARGS ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim.f
src/aes_pkg.sv
src/aes_key_expander.sv
src/aes_round_key_store.sv
src/aes_cipher_core.sv
src/aes_encrypt_top.sv
test/aes_sva.sv
test/aes_checker.sv
test/tb_aes.sv

// File: src/aes_cipher_core.sv
`timescale 1ns/1ns
`default_nettype none

module aes_cipher_core import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       kick_cipher,
    input  block_t     plaintext,
    input  block_t     rd_key,
    output round_idx_t rd_idx,
    output logic       busy,
    output logic       done,
    output block_t     ciphertext
);

    round_idx_t round;
    block_t     state;
    block_t     shifted;
    block_t     round_out;
    block_t     final_out;
    logic       last_round;

    assign rd_idx = round;
    assign last_round = (round == round_idx_t'(num_rounds));

    always_comb begin
        shifted = shift_rows(sub_bytes(state));
        round_out = mix_columns(shifted) ^ rd_key;
        // no mix columns in the last round
        final_out = shifted ^ rd_key;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            round <= '0;
        end else begin
            done <= 1'b0;
            if (kick_cipher) begin
                busy <= 1'b1;
                round <= '0;
            end else if (busy) begin
                if (last_round) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    round <= '0;
                end else begin
                    round <= round + round_idx_t'(1);
                end
            end
        end
    end

    // plaintext captured on kick, key 0 added one cycle later
    always_ff @(posedge clk) begin
        if (kick_cipher) begin
            state <= plaintext;
        end else if (busy) begin
            if (round == '0) begin
                state <= state ^ rd_key;
            end else begin
                state <= round_out;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && last_round) begin
            ciphertext <= final_out;
        end
    end

endmodule

`default_nettype wire

// File: src/aes_encrypt_top.sv
`timescale 1ns/1ns
`default_nettype none

module aes_encrypt_top import aes_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  aes_req_t req,
    output logic     busy,
    output logic     done,
    output block_t   ciphertext
);

    logic       accept;
    logic       kick_expand;
    logic       kick_cipher;
    rk_write_t  rk_write;
    round_idx_t rd_idx;
    block_t     rd_key;

    // start while busy is dropped
    assign accept = start & ~busy;
    assign kick_expand = accept & ~req.reuse_key;
    assign kick_cipher = accept;

    aes_key_expander u_key_expander (
        .clk         (clk),
        .reset       (reset),
        .kick_expand (kick_expand),
        .key         (req.key),
        .rk_write    (rk_write)
    );

    aes_round_key_store u_round_key_store (
        .clk      (clk),
        .reset    (reset),
        .rk_write (rk_write),
        .rd_idx   (rd_idx),
        .rd_key   (rd_key)
    );

    aes_cipher_core u_cipher_core (
        .clk         (clk),
        .reset       (reset),
        .kick_cipher (kick_cipher),
        .plaintext   (req.plaintext),
        .rd_key      (rd_key),
        .rd_idx      (rd_idx),
        .busy        (busy),
        .done        (done),
        .ciphertext  (ciphertext)
    );

endmodule

`default_nettype wire

// File: src/aes_key_expander.sv
`timescale 1ns/1ns
`default_nettype none

module aes_key_expander import aes_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      kick_expand,
    input  block_t    key,
    output rk_write_t rk_write
);

    // last four schedule words, w0 in the top bits
    block_t     cur_key;
    block_t     next_key;
    round_idx_t cnt;
    logic       running;
    logic [31:0] temp;

    always_comb begin
        temp = sub_word(rot_word(cur_key[31:0])) ^ rcon(cnt);
        next_key[127:96] = cur_key[127:96] ^ temp;
        next_key[95:64] = cur_key[95:64] ^ next_key[127:96];
        next_key[63:32] = cur_key[63:32] ^ next_key[95:64];
        next_key[31:0] = cur_key[31:0] ^ next_key[63:32];
    end

    // key 0 goes straight through on the kick cycle
    always_comb begin
        rk_write.valid = kick_expand | running;
        rk_write.idx = kick_expand ? round_idx_t'(0) : cnt;
        rk_write.round_key = kick_expand ? key : next_key;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            cnt <= '0;
        end else if (kick_expand) begin
            running <= 1'b1;
            cnt <= round_idx_t'(1);
        end else if (running) begin
            cnt <= cnt + round_idx_t'(1);
            if (cnt == round_idx_t'(num_rounds)) begin
                running <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (kick_expand) begin
            cur_key <= key;
        end else if (running) begin
            cur_key <= next_key;
        end
    end

endmodule

`default_nettype wire

// File: src/aes_pkg.sv
`default_nettype none

package aes_pkg;

    localparam int block_width = 128;
    localparam int num_rounds = 10;
    localparam int num_round_keys = num_rounds + 1;

    typedef logic [3:0] round_idx_t;
    typedef logic [block_width-1:0] block_t;

    typedef struct packed {
        block_t key;
        block_t plaintext;
        logic   reuse_key;
    } aes_req_t;

    typedef struct packed {
        logic       valid;
        round_idx_t idx;
        block_t     round_key;
    } rk_write_t;

    // multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] p;
        acc = '0;
        p = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc ^= p;
            end
            p = xtime(p);
        end
        return acc;
    endfunction

    function automatic logic [7:0] sbox(input logic [7:0] x);
        logic [7:0] sq;
        logic [7:0] inv;
        sq = x;
        inv = 8'h01;
        // x^254 is the field inverse, zero stays zero
        for (int i = 1; i < 8; i++) begin
            sq = gf_mul(sq, sq);
            inv = gf_mul(inv, sq);
        end
        // affine transform
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    function automatic logic [31:0] rcon(input round_idx_t r);
        logic [7:0] rc;
        rc = 8'h01;
        for (int i = 1; i < num_rounds; i++) begin
            if (i < r) begin
                rc = xtime(rc);
            end
        end
        return {rc, 24'h000000};
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t o;
        for (int i = 0; i < 16; i++) begin
            o[8*i +: 8] = sbox(s[8*i +: 8]);
        end
        return o;
    endfunction

    // byte (r, c) sits at index 4c + r, msb first
    function automatic block_t shift_rows(input block_t s);
        block_t o;
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                o[block_width - 1 - 8*(4*c + r) -: 8] =
                    s[block_width - 1 - 8*(4*((c + r) % 4) + r) -: 8];
            end
        end
        return o;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t o;
        logic [7:0] a [4];
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                a[r] = s[block_width - 1 - 8*(4*c + r) -: 8];
            end
            o[block_width - 1 - 32*c -: 8] = xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
            o[block_width - 9 - 32*c -: 8] = a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3];
            o[block_width - 17 - 32*c -: 8] = a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3];
            o[block_width - 25 - 32*c -: 8] = xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3]);
        end
        return o;
    endfunction

endpackage

`default_nettype wire

// File: src/aes_round_key_store.sv
`timescale 1ns/1ns
`default_nettype none

module aes_round_key_store import aes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  rk_write_t  rk_write,
    input  round_idx_t rd_idx,
    output block_t     rd_key
);

    block_t keys [num_round_keys];

    // contents survive between requests for key reuse
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_round_keys; i++) begin
                keys[i] <= '0;
            end
        end else if (rk_write.valid && rk_write.idx < num_round_keys) begin
            keys[rk_write.idx] <= rk_write.round_key;
        end
    end

    always_comb begin
        if (rd_idx < num_round_keys) begin
            rd_key = keys[rd_idx];
        end else begin
            rd_key = '0;
        end
    end

endmodule

`default_nettype wire

// File: test/aes_checker.sv
`timescale 1ns/1ns
`default_nettype none

module aes_checker import aes_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     busy,
    input  aes_req_t req,
    input  logic     done,
    input  block_t   ciphertext,
    output int       errors,
    output int       checked
);

    // done rises 11 edges after accept and is seen at the next edge
    localparam int done_delay = 12;

    logic [7:0] sbox_tab [256];
    block_t     model_keys [11];
    block_t     expected;
    logic       pending = 1'b0;
    logic       reset_q = 1'b0;
    logic       self_tested = 1'b0;
    int         age = 0;
    int         err_cnt = 0;
    int         done_cnt = 0;

    assign errors = err_cnt;
    assign checked = done_cnt;

    function automatic logic [7:0] mul2(input logic [7:0] b);
        return (b << 1) ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [31:0] sub4(input logic [31:0] w);
        return {sbox_tab[w[31:24]], sbox_tab[w[23:16]], sbox_tab[w[15:8]], sbox_tab[w[7:0]]};
    endfunction

    initial begin
        logic [7:0] p;
        logic [7:0] q;
        logic [7:0] x;
        p = 8'h01;
        q = 8'h01;
        // p walks powers of 3, q the matching inverse
        for (int i = 0; i < 255; i++) begin
            p = p ^ mul2(p);
            q = q ^ (q << 1);
            q = q ^ (q << 2);
            q = q ^ (q << 4);
            if (q[7]) begin
                q = q ^ 8'h09;
            end
            x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
            sbox_tab[p] = x ^ 8'h63;
        end
        sbox_tab[0] = 8'h63;
    end

    task automatic expand_key(input block_t key);
        logic [31:0] w [44];
        logic [31:0] t;
        logic [7:0]  rc;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = key[127 - 32*i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            t = w[i-1];
            if (i % 4 == 0) begin
                t = sub4({t[23:0], t[31:24]}) ^ {rc, 24'h000000};
                rc = mul2(rc);
            end
            w[i] = w[i-4] ^ t;
        end
        for (int r = 0; r < 11; r++) begin
            model_keys[r] = {w[4*r], w[4*r+1], w[4*r+2], w[4*r+3]};
        end
    endtask

    // byte i of the state is column i/4, row i%4
    function automatic block_t encrypt_block(input block_t pt);
        logic [7:0] s [16];
        logic [7:0] t [16];
        logic [7:0] a [4];
        block_t     out;
        for (int i = 0; i < 16; i++) begin
            s[i] = pt[127 - 8*i -: 8] ^ model_keys[0][127 - 8*i -: 8];
        end
        for (int r = 1; r <= 10; r++) begin
            for (int c = 0; c < 4; c++) begin
                for (int row = 0; row < 4; row++) begin
                    t[4*c + row] = sbox_tab[s[4*((c + row) % 4) + row]];
                end
            end
            for (int c = 0; c < 4; c++) begin
                for (int k = 0; k < 4; k++) begin
                    a[k] = t[4*c + k];
                end
                if (r < 10) begin
                    s[4*c] = mul2(a[0] ^ a[1]) ^ a[1] ^ a[2] ^ a[3];
                    s[4*c + 1] = a[0] ^ mul2(a[1] ^ a[2]) ^ a[2] ^ a[3];
                    s[4*c + 2] = a[0] ^ a[1] ^ mul2(a[2] ^ a[3]) ^ a[3];
                    s[4*c + 3] = mul2(a[3] ^ a[0]) ^ a[0] ^ a[1] ^ a[2];
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        s[4*c + k] = a[k];
                    end
                end
            end
            for (int i = 0; i < 16; i++) begin
                s[i] = s[i] ^ model_keys[r][127 - 8*i -: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            out[127 - 8*i -: 8] = s[i];
        end
        return out;
    endfunction

    always @(posedge clk) begin
        if (!self_tested) begin
            expand_key(128'h000102030405060708090a0b0c0d0e0f);
            expected = encrypt_block(128'h00112233445566778899aabbccddeeff);
            if (expected !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
                $display("reference model gives %h for the FIPS-197 vector", expected);
                err_cnt++;
            end
            self_tested = 1'b1;
        end
        if (reset) begin
            pending = 1'b0;
            for (int r = 0; r < 11; r++) begin
                model_keys[r] = '0;
            end
        end else begin
            if (reset_q && (busy || done)) begin
                $display("busy or done still high in the cycle after reset");
                err_cnt++;
            end
            if (done) begin
                if (!pending) begin
                    $display("done pulse without an accepted request");
                    err_cnt++;
                end else begin
                    done_cnt++;
                    if (age != done_delay) begin
                        $display("done came %0d cycles after the accepting edge, not 11",
                                 age - 1);
                        err_cnt++;
                    end
                    if (busy !== 1'b0) begin
                        $display("Error: busy got %h expected %h", busy, 1'b0);
                        err_cnt++;
                    end
                    if (ciphertext !== expected) begin
                        $display("Error: ciphertext got %h expected %h", ciphertext, expected);
                        err_cnt++;
                    end
                    pending = 1'b0;
                end
            end else if (pending && age >= done_delay) begin
                $display("no done for an accepted request");
                err_cnt++;
                pending = 1'b0;
            end
            if (start && !busy) begin
                if (!req.reuse_key) begin
                    expand_key(req.key);
                end
                expected = encrypt_block(req.plaintext);
                pending = 1'b1;
                age = 0;
            end
            if (pending) begin
                age++;
            end
        end
        reset_q = reset;
    end

endmodule

`default_nettype wire

// File: test/aes_sva.sv
`timescale 1ns/1ns
`default_nettype none

module aes_sva (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done
);

    int fail_count = 0;

    a_done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else begin
            fail_count++;
            $error("done held for more than one cycle");
        end

    // eleven samples of busy high, then low
    a_busy_length: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(busy, 11) && !$past(busy, 12))
        else begin
            fail_count++;
            $error("busy did not stay high for exactly 11 cycles");
        end

    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        start && !busy |-> ##12 (done && !busy))
        else begin
            fail_count++;
            $error("no done 11 cycles after an accepted start");
        end

    a_done_after_busy: assert property (@(posedge clk) disable iff (reset)
        done |-> !busy && $past(busy))
        else begin
            fail_count++;
            $error("done without busy falling");
        end

endmodule

`default_nettype wire

// File: test/tb_aes.sv
`timescale 1ns/1ns
`default_nettype none

module tb_aes import aes_pkg::*; ();

    localparam int clk_period = 40;
    localparam int num_random = 24;
    localparam int num_reuse = 8;
    // fips, busy pair, aborted, reuse after reset, last one
    localparam int num_requests = num_random + num_reuse + 6;
    localparam int max_wait = 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        start;
    aes_req_t    req;
    logic        busy;
    logic        done;
    block_t      ciphertext;
    logic [31:0] lfsr = 32'hf8d8;
    int          stalls = 0;
    int          errors;
    int          checked;

    always #(clk_period / 2) clk = ~clk;

    aes_encrypt_top u_aes_encrypt_top (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .req        (req),
        .busy       (busy),
        .done       (done),
        .ciphertext (ciphertext)
    );

    aes_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .busy       (busy),
        .req        (req),
        .done       (done),
        .ciphertext (ciphertext),
        .errors     (errors),
        .checked    (checked)
    );

    bind aes_encrypt_top aes_sva u_aes_sva (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .busy  (busy),
        .done  (done)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_block(output block_t b);
        for (int i = 0; i < block_width; i++) begin
            lfsr = lfsr_step(lfsr);
            b[i] = lfsr[0];
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pulse_start(input block_t key, input block_t pt, input logic reuse);
        start = 1'b1;
        req.key = key;
        req.plaintext = pt;
        req.reuse_key = reuse;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < max_wait) begin
            next_cycle();
            n++;
        end
        if (!done) begin
            $display("no done within %0d cycles of a request", max_wait);
            stalls++;
        end
    endtask

    task automatic encrypt(input block_t key, input block_t pt, input logic reuse);
        pulse_start(key, pt, reuse);
        wait_done();
    endtask

    initial begin
        block_t key;
        block_t pt;
        reset = 1'b1;
        start = 1'b0;
        req = '0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();
        encrypt(128'h000102030405060708090a0b0c0d0e0f,
                128'h00112233445566778899aabbccddeeff, 1'b0);
        for (int i = 0; i < num_random; i++) begin
            rand_block(key);
            rand_block(pt);
            encrypt(key, pt, 1'b0);
        end
        // junk key field, last expanded key applies
        for (int i = 0; i < num_reuse; i++) begin
            rand_block(key);
            rand_block(pt);
            encrypt(key, pt, 1'b1);
        end
        rand_block(key);
        rand_block(pt);
        pulse_start(key, pt, 1'b0);
        repeat (3) next_cycle();
        // lands while busy
        rand_block(key);
        rand_block(pt);
        pulse_start(key, pt, 1'b0);
        wait_done();
        repeat (15) next_cycle();
        // abandon a block with reset
        rand_block(key);
        rand_block(pt);
        pulse_start(key, pt, 1'b0);
        repeat (4) next_cycle();
        reset = 1'b1;
        repeat (3) next_cycle();
        reset = 1'b0;
        repeat (20) next_cycle();
        // round keys are zero again
        rand_block(key);
        rand_block(pt);
        encrypt(key, pt, 1'b1);
        rand_block(key);
        rand_block(pt);
        encrypt(key, pt, 1'b0);
        repeat (3) next_cycle();
        $display("results checked %0d, errors %0d, assertion failures %0d, stalls %0d",
                 checked, errors, u_aes_encrypt_top.u_aes_sva.fail_count, stalls);
        if (errors == 0 && stalls == 0 && u_aes_encrypt_top.u_aes_sva.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(clk_period * (num_requests * 15 + 100));
        $display("timeout, the run did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire
